// ==== hw/mem_pkg.sv ====
package mem_pkg;

  // data word width
  localparam int DATA_W = 16;

  // bank count and bank number width
  localparam int NUM_BANKS = 4;
  localparam int BANK_W = 2;

  // rows per bank and row number width
  localparam int NUM_ROWS = 16;
  localparam int ROW_W = 4;

  // bank number sits in the upper address bits
  localparam int ADDR_W = BANK_W + ROW_W;

  // cycles from a sampled read to rd_vld
  localparam int RD_LATENCY = 2;

  typedef logic [DATA_W-1:0] data_t;
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [BANK_W-1:0] bank_t;
  typedef logic [ROW_W-1:0] row_t;
  // stored word, even parity bit on top
  typedef logic [DATA_W:0] word_t;

endpackage

// ==== hw/bank_array.sv ====
`timescale 1ns/10ps

module bank_array (
  input  logic           clk,
  input  logic           rd_en,
  input  mem_pkg::addr_t rd_addr,
  input  logic           bwr_en,
  input  mem_pkg::addr_t bwr_addr,
  input  mem_pkg::word_t bwr_word,
  output mem_pkg::word_t bank_word
);

  mem_pkg::bank_t rd_bank;
  mem_pkg::row_t  rd_row;
  mem_pkg::bank_t wr_bank;
  mem_pkg::row_t  wr_row;
  mem_pkg::bank_t rd_bank_q;
  mem_pkg::word_t bank_dout [mem_pkg::NUM_BANKS];

  assign rd_bank = rd_addr[mem_pkg::ADDR_W-1 -: mem_pkg::BANK_W];
  assign rd_row  = rd_addr[mem_pkg::ROW_W-1:0];
  assign wr_bank = bwr_addr[mem_pkg::ADDR_W-1 -: mem_pkg::BANK_W];
  assign wr_row  = bwr_addr[mem_pkg::ROW_W-1:0];

  // one single-port array per bank, read has priority on the port
  for (genvar b = 0; b < mem_pkg::NUM_BANKS; b++) begin : g_bank
    mem_pkg::word_t mem [mem_pkg::NUM_ROWS];
    mem_pkg::word_t dout;
    logic           rd_sel;
    logic           wr_sel;

    assign rd_sel = rd_en && (rd_bank == mem_pkg::bank_t'(b));
    assign wr_sel = bwr_en && (wr_bank == mem_pkg::bank_t'(b));

    always_ff @(posedge clk) begin
      if (rd_sel) begin
        dout <= mem[rd_row];
      end else if (wr_sel) begin
        mem[wr_row] <= bwr_word;
      end
    end

    assign bank_dout[b] = dout;
  end

  // remember which bank was read so its output is picked next cycle
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_bank_q <= rd_bank;
    end
  end

  assign bank_word = bank_dout[rd_bank_q];

endmodule

// ==== hw/remap_cache.sv ====
`timescale 1ns/10ps

module remap_cache (
  input  logic           clk,
  input  logic           rst,
  input  logic           rd_en,
  input  mem_pkg::addr_t rd_addr,
  input  logic           wr_en,
  input  mem_pkg::addr_t wr_addr,
  input  mem_pkg::data_t wr_data,
  output logic           bwr_en,
  output mem_pkg::addr_t bwr_addr,
  output mem_pkg::word_t bwr_word,
  output logic           hit,
  output mem_pkg::word_t hit_word
);

  mem_pkg::bank_t rd_bank;
  mem_pkg::row_t  rd_row;
  mem_pkg::bank_t wr_bank;
  mem_pkg::row_t  wr_row;
  mem_pkg::word_t wr_word;

  // map table, one entry per row
  logic [mem_pkg::NUM_ROWS-1:0] map_vld;
  mem_pkg::bank_t               map_bank [mem_pkg::NUM_ROWS];
  // extra word per row for diverted writes
  mem_pkg::word_t               cache_mem [mem_pkg::NUM_ROWS];

  logic           conflict;
  logic           wr_map_vld;
  mem_pkg::bank_t wr_map_bank;
  logic           evict;
  logic           map_clear;
  logic           rd_map_hit;

  assign rd_bank = rd_addr[mem_pkg::ADDR_W-1 -: mem_pkg::BANK_W];
  assign rd_row  = rd_addr[mem_pkg::ROW_W-1:0];
  assign wr_bank = wr_addr[mem_pkg::ADDR_W-1 -: mem_pkg::BANK_W];
  assign wr_row  = wr_addr[mem_pkg::ROW_W-1:0];

  // even parity over the data bits
  assign wr_word = {^wr_data, wr_data};

  // the read owns its bank this cycle, so a write there must divert
  assign conflict = rd_en && wr_en && (rd_bank == wr_bank);

  assign wr_map_vld  = map_vld[wr_row];
  assign wr_map_bank = map_bank[wr_row];

  // cached word of another bank must go home before it is replaced
  assign evict = conflict && wr_map_vld && (wr_map_bank != wr_bank);

  // a direct write makes any cached copy of that address stale
  assign map_clear = wr_en && !conflict && wr_map_vld && (wr_map_bank == wr_bank);

  always_comb begin
    bwr_en   = 1'b0;
    bwr_addr = wr_addr;
    bwr_word = wr_word;
    if (wr_en && !conflict) begin
      bwr_en = 1'b1;
    end else if (evict) begin
      // evicted bank differs from the read bank, so its port is free
      bwr_en   = 1'b1;
      bwr_addr = {wr_map_bank, wr_row};
      bwr_word = cache_mem[wr_row];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      map_vld <= '0;
    end else if (conflict) begin
      map_vld[wr_row] <= 1'b1;
    end else if (map_clear) begin
      map_vld[wr_row] <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (conflict) begin
      map_bank[wr_row]  <= wr_bank;
      cache_mem[wr_row] <= wr_word;
    end
  end

  // lookup uses the map before this edge's update
  assign rd_map_hit = map_vld[rd_row] && (map_bank[rd_row] == rd_bank);

  always_ff @(posedge clk) begin
    if (rst) begin
      hit <= 1'b0;
    end else begin
      hit <= rd_en && rd_map_hit;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_en) begin
      hit_word <= cache_mem[rd_row];
    end
  end

endmodule

// ==== hw/read_merge.sv ====
`timescale 1ns/10ps

module read_merge (
  input  logic           clk,
  input  logic           rst,
  input  logic           rd_en,
  input  mem_pkg::word_t bank_word,
  input  logic           hit,
  input  mem_pkg::word_t hit_word,
  output logic           rd_vld,
  output mem_pkg::data_t rd_data,
  output logic           rd_perr
);

  logic           rd_en_q;
  mem_pkg::word_t sel_word;
  logic           par_err;

  // align the request with the bank and cache lookups
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_en_q <= 1'b0;
    end else begin
      rd_en_q <= rd_en;
    end
  end

  // cache copy wins when the map points at the read address
  assign sel_word = hit ? hit_word : bank_word;
  assign par_err  = ^sel_word;

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_vld  <= 1'b0;
      rd_perr <= 1'b0;
    end else begin
      rd_vld  <= rd_en_q;
      rd_perr <= rd_en_q && par_err;
    end
  end

  always_ff @(posedge clk) begin
    rd_data <= sel_word[mem_pkg::DATA_W-1:0];
  end

endmodule

// ==== hw/remap_mem_top.sv ====
`timescale 1ns/10ps

module remap_mem_top (
  input  logic           clk,
  input  logic           rst,
  input  logic           rd_en,
  input  mem_pkg::addr_t rd_addr,
  input  logic           wr_en,
  input  mem_pkg::addr_t wr_addr,
  input  mem_pkg::data_t wr_data,
  output logic           rd_vld,
  output mem_pkg::data_t rd_data,
  output logic           rd_perr
);

  // bank write side, steered by the cache
  logic           bwr_en;
  mem_pkg::addr_t bwr_addr;
  mem_pkg::word_t bwr_word;

  // first stage read results
  logic           hit;
  mem_pkg::word_t hit_word;
  mem_pkg::word_t bank_word;

  remap_cache u_remap_cache (
    .clk      (clk),
    .rst      (rst),
    .rd_en    (rd_en),
    .rd_addr  (rd_addr),
    .wr_en    (wr_en),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data),
    .bwr_en   (bwr_en),
    .bwr_addr (bwr_addr),
    .bwr_word (bwr_word),
    .hit      (hit),
    .hit_word (hit_word)
  );

  bank_array u_bank_array (
    .clk       (clk),
    .rd_en     (rd_en),
    .rd_addr   (rd_addr),
    .bwr_en    (bwr_en),
    .bwr_addr  (bwr_addr),
    .bwr_word  (bwr_word),
    .bank_word (bank_word)
  );

  read_merge u_read_merge (
    .clk       (clk),
    .rst       (rst),
    .rd_en     (rd_en),
    .bank_word (bank_word),
    .hit       (hit),
    .hit_word  (hit_word),
    .rd_vld    (rd_vld),
    .rd_data   (rd_data),
    .rd_perr   (rd_perr)
  );

endmodule

// ==== tests/remap_mem_tb.sv ====
`timescale 1ns/10ps

module remap_mem_tb;

  // about 2300 cycles of tests, with margin
  localparam int TIMEOUT_CYCLES = 3000;
  localparam int NUM_WORDS = mem_pkg::NUM_BANKS * mem_pkg::NUM_ROWS;

  logic           clk = 1'b0;
  logic           rst;
  logic           rd_en;
  mem_pkg::addr_t rd_addr;
  logic           wr_en;
  mem_pkg::addr_t wr_addr;
  mem_pkg::data_t wr_data;
  logic           rd_vld;
  mem_pkg::data_t rd_data;
  logic           rd_perr;

  // reference model
  mem_pkg::data_t model_data [NUM_WORDS];
  bit             model_written [NUM_WORDS];
  mem_pkg::data_t exp_q [$];

  logic [mem_pkg::RD_LATENCY-1:0] vld_pipe;
  int cycle_count = 0;

  remap_mem_top UUT (
    .clk     (clk),
    .rst     (rst),
    .rd_en   (rd_en),
    .rd_addr (rd_addr),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .rd_vld  (rd_vld),
    .rd_data (rd_data),
    .rd_perr (rd_perr)
  );

  always #10 clk = ~clk;

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("=== FAIL ===");
    $fatal(1);
  endtask

  function automatic mem_pkg::addr_t make_addr(input mem_pkg::bank_t b, input mem_pkg::row_t r);
    return {b, r};
  endfunction

  // one request cycle, model read happens before the same cycle's write
  task automatic drive_cycle(input logic re, input mem_pkg::addr_t ra, input logic we,
                             input mem_pkg::addr_t wa, input mem_pkg::data_t wd);
    @(posedge clk);
    #2;
    rd_en   = re;
    rd_addr = ra;
    wr_en   = we;
    wr_addr = wa;
    wr_data = wd;
    if (re) begin
      exp_q.push_back(model_data[ra]);
    end
    if (we) begin
      model_data[wa]    = wd;
      model_written[wa] = 1'b1;
    end
  endtask

  task automatic read_addr(input mem_pkg::addr_t a);
    drive_cycle(1'b1, a, 1'b0, '0, '0);
  endtask

  // idle until every outstanding read has come back
  task automatic drain_reads();
    while (exp_q.size() != 0) begin
      drive_cycle(1'b0, '0, 1'b0, '0, '0);
    end
    repeat (3) drive_cycle(1'b0, '0, 1'b0, '0, '0);
  endtask

  // rows 0 to 2 are hot so conflicts and evictions are frequent
  function automatic mem_pkg::addr_t pick_addr();
    mem_pkg::bank_t b;
    mem_pkg::row_t  r;
    b = mem_pkg::bank_t'($urandom % mem_pkg::NUM_BANKS);
    if ($urandom % 4 != 0) begin
      r = mem_pkg::row_t'($urandom % 3);
    end else begin
      r = mem_pkg::row_t'($urandom % mem_pkg::NUM_ROWS);
    end
    return make_addr(b, r);
  endfunction

  // sampled read enables, aligned with rd_vld
  always @(posedge clk) begin
    if (rst) begin
      vld_pipe <= '0;
    end else begin
      vld_pipe <= {vld_pipe[mem_pkg::RD_LATENCY-2:0], rd_en};
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      fail_run("timeout, the tests did not finish within the cycle limit");
    end
  end

  // outputs are stable at the falling edge
  always @(negedge clk) begin
    mem_pkg::data_t exp;
    if (!rst) begin
      assert (rd_vld == vld_pipe[mem_pkg::RD_LATENCY-1]) else
        fail_run($sformatf("ERROR rd_vld expected %h got %h",
                           vld_pipe[mem_pkg::RD_LATENCY-1], rd_vld));
      assert (rd_perr == 1'b0) else
        fail_run($sformatf("ERROR rd_perr expected %h got %h", 1'b0, rd_perr));
      if (rd_vld) begin
        exp = exp_q.pop_front();
        assert (rd_data == exp) else
          fail_run($sformatf("ERROR rd_data expected %h got %h", exp, rd_data));
      end
    end
  end

  initial begin
    mem_pkg::addr_t a0;
    mem_pkg::addr_t a1;
    logic           re;
    logic           we;
    void'($urandom(32'hc3b2_6004));
    rst     = 1'b1;
    rd_en   = 1'b0;
    rd_addr = '0;
    wr_en   = 1'b0;
    wr_addr = '0;
    wr_data = '0;
    repeat (10) @(posedge clk);
    #2;
    rst = 1'b0;

    // fill every address, then read back to back
    for (int a = 0; a < NUM_WORDS; a++) begin
      drive_cycle(1'b0, '0, 1'b1, mem_pkg::addr_t'(a), mem_pkg::data_t'($urandom));
    end
    for (int a = 0; a < NUM_WORDS; a++) begin
      read_addr(mem_pkg::addr_t'(a));
    end
    drain_reads();

    // same bank read and write, the write lands in the cache
    for (int b = 0; b < mem_pkg::NUM_BANKS; b++) begin
      a0 = make_addr(mem_pkg::bank_t'(b), mem_pkg::row_t'(0));
      a1 = make_addr(mem_pkg::bank_t'(b), mem_pkg::row_t'(5));
      drive_cycle(1'b1, a0, 1'b1, a1, mem_pkg::data_t'($urandom));
      read_addr(a1);
      read_addr(a0);
    end
    drain_reads();

    // second diverted write to row 9 evicts the first one
    a0 = make_addr(mem_pkg::bank_t'(0), mem_pkg::row_t'(9));
    a1 = make_addr(mem_pkg::bank_t'(1), mem_pkg::row_t'(9));
    drive_cycle(1'b1, make_addr(2'd0, 4'd2), 1'b1, a0, mem_pkg::data_t'($urandom));
    drive_cycle(1'b1, make_addr(2'd1, 4'd3), 1'b1, a1, mem_pkg::data_t'($urandom));
    read_addr(a0);
    read_addr(a1);
    // direct writes must not be shadowed by a stale cache word
    drive_cycle(1'b0, '0, 1'b1, a0, mem_pkg::data_t'($urandom));
    drive_cycle(1'b1, make_addr(2'd2, 4'd9), 1'b1, a1, mem_pkg::data_t'($urandom));
    read_addr(a0);
    read_addr(a1);
    drain_reads();

    // read and write of one address in one cycle
    for (int i = 0; i < 4; i++) begin
      a0 = pick_addr();
      drive_cycle(1'b1, a0, 1'b1, a0, mem_pkg::data_t'($urandom));
      read_addr(a0);
    end
    drain_reads();

    // random traffic
    for (int i = 0; i < 2000; i++) begin
      a0 = pick_addr();
      a1 = pick_addr();
      re = ($urandom % 4 != 0) && model_written[a0];
      we = ($urandom % 3 != 0);
      drive_cycle(re, a0, we, a1, mem_pkg::data_t'($urandom));
    end
    drain_reads();

    $display("=== PASS ===");
    $finish;
  end

endmodule

// ==== list.f ====
hw/mem_pkg.sv
hw/bank_array.sv
hw/remap_cache.sv
hw/read_merge.sv
hw/remap_mem_top.sv
tests/remap_mem_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f list.f --top-module remap_mem_tb -o Vremap_mem_tb

# the simulator exit status is not used, the log decides
./obj_dir/Vremap_mem_tb 2>&1 | tee sim.log

if grep -q "=== FAIL ===" sim.log; then
  echo "simulation reported a failure, see sim.log"
  exit 1
fi
if ! grep -q "=== PASS ===" sim.log; then
  echo "simulation ended without a result, see sim.log"
  exit 1
fi
echo "simulation passed"
